// File: src/mont_cfg.svh
`ifndef MONT_CFG_SVH
`define MONT_CFG_SVH

// operand width in bits, any even value
`define MONT_WIDTH 64

// one radix-4 digit per pipeline stage
`define MONT_DIGITS (`MONT_WIDTH / 2)

// feeder + digit stages + drain
`define MONT_LATENCY (`MONT_DIGITS + 2)

`endif

// File: src/mont_pkg.sv
`default_nettype none

package mont_pkg;

    `include "mont_cfg.svh"

    // inputs, result, plain B and M
    typedef logic [`MONT_WIDTH-1:0] operand_t;

    // room for 3B, 3M and the accumulator (C < 2M)
    typedef logic [`MONT_WIDTH+1:0] ext_t;

    // adder width inside a stage, C + 3B + 3M < 8M
    typedef logic [`MONT_WIDTH+3:0] sum_t;

    // one radix-4 digit
    typedef logic [1:0] digit_t;

endpackage

`default_nettype wire

// File: src/mont_multiple_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mont_multiple_gen (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  mont_pkg::operand_t a,
    input  mont_pkg::operand_t b,
    input  mont_pkg::operand_t m,
    output logic               valid,
    output mont_pkg::operand_t a_rem,
    output mont_pkg::ext_t     b1,
    output mont_pkg::ext_t     b2,
    output mont_pkg::ext_t     b3,
    output mont_pkg::ext_t     m1,
    output mont_pkg::ext_t     m2,
    output mont_pkg::ext_t     m3
);

    import mont_pkg::*;

    ext_t b_x1;
    ext_t b_x2;
    ext_t b_x3;
    ext_t m_x1;
    ext_t m_x2;
    ext_t m_x3;

    // widen first so the doubles and triples keep their carries
    assign b_x1 = ext_t'(b);
    assign m_x1 = ext_t'(m);

    assign b_x2 = b_x1 << 1;          // 2B by wiring
    assign m_x2 = m_x1 << 1;          // 2M by wiring

    // one adder each for the triples
    assign b_x3 = b_x2 + b_x1;
    assign m_x3 = m_x2 + m_x1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else begin
            valid <= start;               // one op enters the pipe
        end
    end

    // operand capture, only on start
    always_ff @(posedge clk) begin
        if (start) begin
            a_rem <= a;
            b1    <= b_x1;
            b2    <= b_x2;
            b3    <= b_x3;
            m1    <= m_x1;
            m2    <= m_x2;
            m3    <= m_x3;
        end
    end

endmodule

`default_nettype wire

// File: src/mont_digit_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mont_cfg.svh"

module mont_digit_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  mont_pkg::operand_t in_a_rem,
    input  mont_pkg::ext_t     in_c,
    input  mont_pkg::ext_t     in_b1,
    input  mont_pkg::ext_t     in_b2,
    input  mont_pkg::ext_t     in_b3,
    input  mont_pkg::ext_t     in_m1,
    input  mont_pkg::ext_t     in_m2,
    input  mont_pkg::ext_t     in_m3,
    output logic               out_valid,
    output mont_pkg::operand_t out_a_rem,
    output mont_pkg::ext_t     out_c,
    output mont_pkg::ext_t     out_b1,
    output mont_pkg::ext_t     out_b2,
    output mont_pkg::ext_t     out_b3,
    output mont_pkg::ext_t     out_m1,
    output mont_pkg::ext_t     out_m2,
    output mont_pkg::ext_t     out_m3
);

    import mont_pkg::*;

    digit_t a_digit;
    digit_t q_digit;
    ext_t   b_sel;
    ext_t   m_sel;
    sum_t   sum_ab;
    sum_t   sum_abm;

    assign a_digit = in_a_rem[1:0];       // lowest unconsumed digit of A

    // a_i * B
    always_comb begin
        case (a_digit)
            2'd1:    b_sel = in_b1;
            2'd2:    b_sel = in_b2;
            2'd3:    b_sel = in_b3;
            default: b_sel = '0;
        endcase
    end

    assign sum_ab = sum_t'(in_c) + sum_t'(b_sel);

    // q = -sum * M^-1 mod 4, M is odd so M[1:0] is 01 or 11
    always_comb begin
        case ({sum_ab[1:0], in_m1[1:0]})
            4'b01_01, 4'b11_11: q_digit = 2'd3;
            4'b10_01, 4'b10_11: q_digit = 2'd2;
            4'b11_01, 4'b01_11: q_digit = 2'd1;
            default:            q_digit = 2'd0;
        endcase
    end

    // q * M
    always_comb begin
        case (q_digit)
            2'd1:    m_sel = in_m1;
            2'd2:    m_sel = in_m2;
            2'd3:    m_sel = in_m3;
            default: m_sel = '0;
        endcase
    end

    // low two bits are zero here by choice of q
    assign sum_abm = sum_ab + sum_t'(m_sel);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_a_rem <= in_a_rem >> 2;               // next digit moves down
        out_c     <= sum_abm[`MONT_WIDTH+3:2];    // divide by 4, result < 2M
        out_b1    <= in_b1;
        out_b2    <= in_b2;
        out_b3    <= in_b3;
        out_m1    <= in_m1;
        out_m2    <= in_m2;
        out_m3    <= in_m3;
    end

endmodule

`default_nettype wire

// File: src/mont_final_sub.sv
`timescale 1ns/1ps
`default_nettype none

`include "mont_cfg.svh"

module mont_final_sub (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  mont_pkg::ext_t     in_c,
    input  mont_pkg::ext_t     in_m,
    output mont_pkg::operand_t result,
    output logic               done
);

    import mont_pkg::*;

    sum_t diff;
    logic diff_neg;

    // extra top bits act as the borrow
    assign diff     = sum_t'(in_c) - sum_t'(in_m);
    assign diff_neg = diff[`MONT_WIDTH+3];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= in_valid;
        end
    end

    // C < 2M, so one subtraction brings it below M
    always_ff @(posedge clk) begin
        if (in_valid) begin
            if (diff_neg) begin
                result <= in_c[`MONT_WIDTH-1:0];      // already reduced
            end else begin
                result <= diff[`MONT_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/montgomery.sv
`timescale 1ns/1ps
`default_nettype none

`include "mont_cfg.svh"

module montgomery (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  mont_pkg::operand_t a,
    input  mont_pkg::operand_t b,
    input  mont_pkg::operand_t m,
    output mont_pkg::operand_t result,
    output logic               done
);

    import mont_pkg::*;

    // index i feeds stage i, index DIGITS goes to the drain
    logic     valid_s [0:`MONT_DIGITS];
    ext_t     c_s     [0:`MONT_DIGITS];
    ext_t     m1_s    [0:`MONT_DIGITS];

    // not needed past the last stage
    operand_t a_rem_s [0:`MONT_DIGITS-1];
    ext_t     b1_s    [0:`MONT_DIGITS-1];
    ext_t     b2_s    [0:`MONT_DIGITS-1];
    ext_t     b3_s    [0:`MONT_DIGITS-1];
    ext_t     m2_s    [0:`MONT_DIGITS-1];
    ext_t     m3_s    [0:`MONT_DIGITS-1];

    assign c_s[0] = '0;                   // accumulator starts at zero

    mont_multiple_gen u_feed (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .valid  (valid_s[0]),
        .a_rem  (a_rem_s[0]),
        .b1     (b1_s[0]),
        .b2     (b2_s[0]),
        .b3     (b3_s[0]),
        .m1     (m1_s[0]),
        .m2     (m2_s[0]),
        .m3     (m3_s[0])
    );

    for (genvar i = 0; i < `MONT_DIGITS; i++) begin : g_stage
        if (i < `MONT_DIGITS - 1) begin : g_mid
            mont_digit_stage u_stage (
                .clk       (clk),
                .resetn    (resetn),
                .in_valid  (valid_s[i]),
                .in_a_rem  (a_rem_s[i]),
                .in_c      (c_s[i]),
                .in_b1     (b1_s[i]),
                .in_b2     (b2_s[i]),
                .in_b3     (b3_s[i]),
                .in_m1     (m1_s[i]),
                .in_m2     (m2_s[i]),
                .in_m3     (m3_s[i]),
                .out_valid (valid_s[i+1]),
                .out_a_rem (a_rem_s[i+1]),
                .out_c     (c_s[i+1]),
                .out_b1    (b1_s[i+1]),
                .out_b2    (b2_s[i+1]),
                .out_b3    (b3_s[i+1]),
                .out_m1    (m1_s[i+1]),
                .out_m2    (m2_s[i+1]),
                .out_m3    (m3_s[i+1])
            );
        end else begin : g_last
            // only valid, C and M continue to the drain
            mont_digit_stage u_stage (
                .clk       (clk),
                .resetn    (resetn),
                .in_valid  (valid_s[i]),
                .in_a_rem  (a_rem_s[i]),
                .in_c      (c_s[i]),
                .in_b1     (b1_s[i]),
                .in_b2     (b2_s[i]),
                .in_b3     (b3_s[i]),
                .in_m1     (m1_s[i]),
                .in_m2     (m2_s[i]),
                .in_m3     (m3_s[i]),
                .out_valid (valid_s[i+1]),
                .out_a_rem (),
                .out_c     (c_s[i+1]),
                .out_b1    (),
                .out_b2    (),
                .out_b3    (),
                .out_m1    (m1_s[i+1]),
                .out_m2    (),
                .out_m3    ()
            );
        end
    end

    mont_final_sub u_drain (
        .clk      (clk),
        .resetn   (resetn),
        .in_valid (valid_s[`MONT_DIGITS]),
        .in_c     (c_s[`MONT_DIGITS]),
        .in_m     (m1_s[`MONT_DIGITS]),
        .result   (result),
        .done     (done)
    );

endmodule

`default_nettype wire

// File: sim/mont_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "mont_cfg.svh"

module mont_properties (
    input logic clk,
    input logic resetn,
    input logic start,
    input logic done
);

    int n_fail = 0;                       // failed assertions so far

    // cleared by reset, still low in the first cycle after it
    reset_clears_done: assert property (
        @(posedge clk) !resetn |=> !done
    ) else begin
        n_fail++;
        $error("done high after a reset cycle");
    end

    // fixed pipeline depth
    done_after_start: assert property (
        @(posedge clk) disable iff (!resetn)
        start |-> ##(`MONT_LATENCY) done
    ) else begin
        n_fail++;
        $error("done missing at start + latency");
    end

    // every done traces back to one start
    no_spurious_done: assert property (
        @(posedge clk) disable iff (!resetn)
        done |-> $past(start, `MONT_LATENCY)
    ) else begin
        n_fail++;
        $error("done without a matching start");
    end

endmodule

`default_nettype wire

// File: sim/tb_montgomery.sv
`timescale 1ns/1ps
`default_nettype none

`include "mont_cfg.svh"

module tb_montgomery;

    import mont_pkg::*;

    localparam int clk_half     = 4;
    localparam int clk_period   = 2 * clk_half;
    localparam int reset_cycles = 10;
    localparam int gap_cycles   = 6;          // idle after an isolated start
    localparam int n_directed   = 7;
    localparam int n_isolated   = 8;
    localparam int n_b2b        = 40;
    localparam int n_per_class  = 8;
    localparam int n_paths      = 4;
    localparam int n_pre_reset  = 10;
    localparam int n_post_reset = 3;
    localparam int n_phases     = 7;
    localparam int total_starts = n_directed + n_isolated + n_b2b + 2 * n_per_class
                                  + n_paths + n_pre_reset + n_post_reset;
    // every phase and every isolated op drains the whole pipe once
    localparam int timeout_cycles = 2 * reset_cycles + total_starts
                                    + (n_phases + n_isolated) * (`MONT_LATENCY + 20) + 20;

    logic     clk;
    logic     resetn;
    logic     start;
    operand_t a;
    operand_t b;
    operand_t m;
    operand_t result;
    logic     done;

    int       seed = 26148;
    operand_t exp_q[$];                       // one entry per start, in order
    int       n_expected = 0;
    int       n_checked = 0;
    int       n_path_sub = 0;
    int       n_path_keep = 0;

    montgomery dut0 (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    bind montgomery mont_properties u_props (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .done   (done)
    );

    initial clk = 1'b0;
    always #(clk_half) clk = ~clk;

    // bit-serial radix-2 Montgomery, value before the final subtraction
    function automatic logic [`MONT_WIDTH+1:0] mont_presub(input operand_t av,
                                                           input operand_t bv,
                                                           input operand_t mv);
        logic [`MONT_WIDTH+2:0] u;
        u = '0;
        for (int i = 0; i < `MONT_WIDTH; i++) begin
            if (av[i]) begin
                u = u + bv;
            end
            if (u[0]) begin
                u = u + mv;                   // make it even
            end
            u = u >> 1;
        end
        return u[`MONT_WIDTH+1:0];
    endfunction

    function automatic operand_t mont_ref(input operand_t av, input operand_t bv,
                                          input operand_t mv);
        logic [`MONT_WIDTH+1:0] u;
        u = mont_presub(av, bv, mv);
        if (u >= mv) begin
            u = u - mv;
        end
        return u[`MONT_WIDTH-1:0];
    endfunction

    function automatic operand_t rand_word();
        operand_t    w;
        logic [31:0] r;
        w = '0;
        for (int k = 0; k < `MONT_WIDTH; k += 32) begin
            r = $random(seed);
            w = (w << 32) | operand_t'(r);
        end
        return w;
    endfunction

    // odd, top bit set, low bits as asked
    function automatic operand_t rand_modulus(input logic [1:0] low);
        operand_t w;
        w = rand_word();
        w[`MONT_WIDTH-1] = 1'b1;
        w[1:0] = low;
        return w;
    endfunction

    function automatic logic [1:0] rand_class();
        logic [31:0] r;
        r = $random(seed);
        return {r[0], 1'b1};
    endfunction

    // M > 2^(W-1), so one subtraction is enough
    function automatic operand_t rand_below(input operand_t mv);
        operand_t w;
        w = rand_word();
        if (w >= mv) begin
            w = w - mv;
        end
        return w;
    endfunction

    task automatic compare_value(input string name, input operand_t actual,
                                 input operand_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic issue_op(input operand_t av, input operand_t bv, input operand_t mv);
        @(posedge clk);
        start <= 1'b1;
        a     <= av;
        b     <= bv;
        m     <= mv;
        if (mont_presub(av, bv, mv) >= mv) begin
            n_path_sub++;
        end else begin
            n_path_keep++;
        end
        exp_q.push_back(mont_ref(av, bv, mv));
        n_expected++;
    endtask

    task automatic hold_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            start <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            start <= 1'b0;
            cnt++;
            if (cnt > `MONT_LATENCY + 10) begin
                $display("results still missing long after the last start");
                $display("STATUS: FAIL");
                $fatal(1, "pipeline did not drain");
            end
        end
        hold_idle(2);
    endtask

    task automatic run_directed();
        operand_t mv;
        operand_t ones;
        mv   = rand_modulus(2'b11);
        ones = '1;
        issue_op('0, rand_below(mv), mv);
        issue_op(operand_t'(1), rand_below(mv), mv);
        issue_op(rand_below(mv), operand_t'(1), mv);
        issue_op(mv - 1, mv - 1, mv);
        issue_op(operand_t'(2), operand_t'(2), operand_t'(3));    // tiny modulus
        issue_op(ones - 1, ones - 1, ones);
        issue_op(operand_t'(1), operand_t'(1), ones);
        wait_drain();
    endtask

    task automatic run_isolated();
        operand_t mv;
        int       cnt;
        for (int i = 0; i < n_isolated; i++) begin
            mv = rand_modulus(rand_class());
            issue_op(rand_below(mv), rand_below(mv), mv);
            @(posedge clk);                   // edge that samples start
            start <= 1'b0;
            cnt = 0;
            while (done !== 1'b1 && cnt <= `MONT_LATENCY + 10) begin
                @(posedge clk);
                cnt++;
            end
            compare_value("done latency", operand_t'(cnt), operand_t'(`MONT_LATENCY));
            hold_idle(gap_cycles);
        end
    endtask

    task automatic run_back_to_back();
        operand_t mv;
        for (int i = 0; i < n_b2b; i++) begin
            mv = rand_modulus(rand_class());
            issue_op(rand_below(mv), rand_below(mv), mv);
        end
        wait_drain();
    endtask

    // M ending in 01 and in 11 covers every quotient row
    task automatic run_modulus_classes();
        operand_t mv;
        for (int cls = 0; cls < 2; cls++) begin
            for (int i = 0; i < n_per_class; i++) begin
                mv = rand_modulus(cls == 0 ? 2'b01 : 2'b11);
                issue_op(rand_below(mv), rand_below(mv), mv);
            end
        end
        wait_drain();
    endtask

    task automatic run_sub_paths();
        operand_t mv;
        operand_t av;
        operand_t bv;
        int       found;
        for (int want = 0; want < 2; want++) begin
            found = 0;
            for (int tries = 0; tries < 500 && found < n_paths / 2; tries++) begin
                mv = rand_modulus(rand_class());
                av = rand_below(mv);
                bv = rand_below(mv);
                if ((mont_presub(av, bv, mv) >= mv) == (want == 1)) begin
                    issue_op(av, bv, mv);
                    found++;
                end
            end
            if (found < n_paths / 2) begin
                $display("no operands found for one final subtraction path");
                $display("STATUS: FAIL");
                $fatal(1, "path search failed");
            end
        end
        wait_drain();
    endtask

    task automatic run_reset_midstream();
        operand_t mv;
        for (int i = 0; i < n_pre_reset; i++) begin
            mv = rand_modulus(rand_class());
            issue_op(rand_below(mv), rand_below(mv), mv);
        end
        @(posedge clk);
        start  <= 1'b0;
        resetn <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        n_expected -= exp_q.size();           // in-flight ops are lost
        exp_q.delete();
        resetn <= 1'b1;
        hold_idle(`MONT_LATENCY + 5);         // any done here has an empty queue
        for (int i = 0; i < n_post_reset; i++) begin
            mv = rand_modulus(rand_class());
            issue_op(rand_below(mv), rand_below(mv), mv);
        end
        wait_drain();
    endtask

    // scoreboard
    always @(posedge clk) begin
        if (done === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("done pulse with no operation pending");
                $display("STATUS: FAIL");
                $fatal(1, "unexpected done");
            end else begin
                compare_value("result", result, exp_q.pop_front());
                n_checked++;
            end
        end
    end

    // bound checker on the done timing
    always @(posedge clk) begin
        if (dut0.u_props.n_fail != 0) begin
            $display("a timing assertion on done failed");
            $display("STATUS: FAIL");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        resetn = 1'b0;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        m      = '0;
        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b1;
        hold_idle(2);

        run_directed();
        run_isolated();
        run_back_to_back();
        run_modulus_classes();
        run_sub_paths();
        run_reset_midstream();
        hold_idle(4);

        if (n_checked != n_expected || n_path_sub == 0 || n_path_keep == 0
            || dut0.u_props.n_fail != 0) begin
            $display("checked %0d of %0d results, subtract path %0d, keep path %0d",
                     n_checked, n_expected, n_path_sub, n_path_keep);
            $display("assertion failures %0d", dut0.u_props.n_fail);
            $display("STATUS: FAIL");
            $fatal(1, "incomplete run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("simulation did not finish in the expected time");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
src/mont_pkg.sv
src/mont_multiple_gen.sv
src/mont_digit_stage.sv
src/mont_final_sub.sv
src/montgomery.sv
sim/mont_properties.sv
sim/tb_montgomery.sv

// File: Bender.yml
package:
  name: montgomery

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/mont_pkg.sv
      - src/mont_multiple_gen.sv
      - src/mont_digit_stage.sv
      - src/mont_final_sub.sv
      - src/montgomery.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/mont_properties.sv
      - sim/tb_montgomery.sv
